// File: logic/mmul_pkg.sv
/*
  Modular matrix-product engine shared definitions.
  Widths, vector types, the configuration word and the FSM encodings.
*/

package mmul_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Operand, modulus and result width
  localparam int data_w = 16;

  // Row and column count width
  localparam int index_w = 8;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  // Operands, modulus and products
  typedef logic [data_w-1:0] data_t;

  // Matrix sizes and loop counters
  typedef logic [index_w-1:0] index_t;

  ////////////////////////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////////////////////////

  // Latched on start, 32 bits in total
  typedef struct packed {
    data_t  modulo;
    index_t size_i;
    index_t size_j;
  } mat_cfg_t;

  ////////////////////////////////////////////////////////////
  // FSM encodings
  ////////////////////////////////////////////////////////////

  // Scalar shift-and-add multiplier
  typedef enum logic [1:0] {
    mod_idle,
    mod_shift,
    mod_done
  } mod_state_t;

  // Row engine
  typedef enum logic [1:0] {
    vec_idle,
    vec_collect,
    vec_compute,
    vec_emit
  } vec_state_t;

  // Matrix controller
  typedef enum logic [1:0] {
    mat_idle,
    mat_row,
    mat_finish
  } mat_state_t;

endpackage

// File: logic/modular_multiplier.sv
/*
  Modular multiplier.
  Interleaved shift-and-add over data_b from the MSB, reduced at each step.
  Fixed latency of data_w + 1 cycles from start to done.
*/

`timescale 1ns/100ps

module modular_multiplier (
  input  logic            CLK,
  input  logic            RST,
  input  logic            start,
  input  mmul_pkg::data_t modulo,
  input  mmul_pkg::data_t data_a,
  input  mmul_pkg::data_t data_b,
  output logic            done,
  output mmul_pkg::data_t product
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  mmul_pkg::mod_state_t state;

  // Steps left in the current product
  mmul_pkg::index_t step_cnt;

  // Accumulator and remaining multiplier bits
  mmul_pkg::data_t acc;
  mmul_pkg::data_t b_sh;

  // One extra bit for the doubled or summed value
  logic [mmul_pkg::data_w:0] wide_mod;
  logic [mmul_pkg::data_w:0] dbl;
  logic [mmul_pkg::data_w:0] dbl_red;
  logic [mmul_pkg::data_w:0] sum;
  logic [mmul_pkg::data_w:0] sum_red;

  ////////////////////////////////////////////////////////////
  // Step datapath
  ////////////////////////////////////////////////////////////

  always_comb begin
    wide_mod = {1'b0, modulo};
    // acc * 2, one subtraction is enough since acc < modulo
    dbl = {acc, 1'b0};
    dbl_red = (dbl >= wide_mod) ? (dbl - wide_mod) : dbl;
    // Conditional add of data_a, again below 2 * modulo
    sum = dbl_red + {1'b0, data_a};
    sum_red = (sum >= wide_mod) ? (sum - wide_mod) : sum;
  end

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= mmul_pkg::mod_idle;
      step_cnt <= '0;
    end else begin
      case (state)
        mmul_pkg::mod_idle: begin
          if (start) begin
            step_cnt <= mmul_pkg::index_t'(mmul_pkg::data_w - 1);
            state <= mmul_pkg::mod_shift;
          end
        end
        mmul_pkg::mod_shift: begin
          // Last bit consumed, flag the product next cycle
          if (step_cnt == '0) begin
            state <= mmul_pkg::mod_done;
          end else begin
            step_cnt <= step_cnt - 1'b1;
          end
        end
        default: begin
          state <= mmul_pkg::mod_idle;
        end
      endcase
    end
  end

  // Accumulator and bit shifter
  always_ff @(posedge CLK) begin
    if (state == mmul_pkg::mod_idle && start) begin
      acc <= '0;
      b_sh <= data_b;
    end else if (state == mmul_pkg::mod_shift) begin
      acc <= b_sh[mmul_pkg::data_w-1] ? sum_red[mmul_pkg::data_w-1:0]
                                       : dbl_red[mmul_pkg::data_w-1:0];
      b_sh <= {b_sh[mmul_pkg::data_w-2:0], 1'b0};
    end
  end

  assign done = (state == mmul_pkg::mod_done);
  assign product = acc;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Reduction by one subtraction relies on a reduced operand
  assert property (@(posedge CLK) disable iff (RST) start |-> (data_a < modulo))
    else $error("modular_multiplier: data_a not below modulo at start");

  // A new product only once the previous one has been flagged
  assert property (@(posedge CLK) disable iff (RST) start |-> (state == mmul_pkg::mod_idle))
    else $error("modular_multiplier: start while busy");

endmodule

// File: logic/vector_multiplier.sv
/*
  Row engine.
  Collects one operand pair per column, runs the modular multiplier
  and emits each product, flagging the last column of the row.
*/

`timescale 1ns/100ps

module vector_multiplier (
  input  logic             CLK,
  input  logic             RST,
  input  logic             row_start,
  input  mmul_pkg::data_t  modulo,
  input  mmul_pkg::index_t size_j,
  input  logic             a_enable,
  input  logic             b_enable,
  input  mmul_pkg::data_t  data_a,
  input  mmul_pkg::data_t  data_b,
  output logic             elem_enable,
  output mmul_pkg::data_t  elem_data,
  output logic             row_done
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  mmul_pkg::vec_state_t state;

  // Column position within the row
  mmul_pkg::index_t col;

  // Operand captured flags, filled in any order
  logic a_got;
  logic b_got;

  // Row configuration and operand holding registers
  mmul_pkg::data_t  mod_reg;
  mmul_pkg::index_t size_reg;
  mmul_pkg::data_t  a_reg;
  mmul_pkg::data_t  b_reg;

  // Scalar multiplier handshake
  logic            mul_start;
  logic            mul_done;
  mmul_pkg::data_t product;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= mmul_pkg::vec_idle;
      col <= '0;
      a_got <= 1'b0;
      b_got <= 1'b0;
      mul_start <= 1'b0;
      elem_enable <= 1'b0;
      row_done <= 1'b0;
    end else begin
      // Single-cycle strobes
      mul_start <= 1'b0;
      elem_enable <= 1'b0;
      row_done <= 1'b0;
      case (state)
        mmul_pkg::vec_idle: begin
          if (row_start) begin
            col <= '0;
            state <= mmul_pkg::vec_collect;
          end
        end
        mmul_pkg::vec_collect: begin
          if (a_got && b_got) begin
            a_got <= 1'b0;
            b_got <= 1'b0;
            mul_start <= 1'b1;
            state <= mmul_pkg::vec_compute;
          end else begin
            a_got <= a_got | a_enable;
            b_got <= b_got | b_enable;
          end
        end
        mmul_pkg::vec_compute: begin
          if (mul_done) begin
            elem_enable <= 1'b1;
            // Last column closes the row
            row_done <= (col == size_reg - 1'b1);
            state <= mmul_pkg::vec_emit;
          end
        end
        default: begin
          // Emit cycle, go on to the next column or wait for a row
          col <= col + 1'b1;
          state <= row_done ? mmul_pkg::vec_idle : mmul_pkg::vec_collect;
        end
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge CLK) begin
    if (state == mmul_pkg::vec_idle && row_start) begin
      mod_reg <= modulo;
      size_reg <= size_j;
    end
    if (state == mmul_pkg::vec_collect && a_enable) a_reg <= data_a;
    if (state == mmul_pkg::vec_collect && b_enable) b_reg <= data_b;
    if (state == mmul_pkg::vec_compute && mul_done) elem_data <= product;
  end

  ////////////////////////////////////////////////////////////
  // Scalar multiplier
  ////////////////////////////////////////////////////////////

  modular_multiplier u_mul (
    .CLK     (CLK),
    .RST     (RST),
    .start   (mul_start),
    .modulo  (mod_reg),
    .data_a  (a_reg),
    .data_b  (b_reg),
    .done    (mul_done),
    .product (product)
  );

  // Host strobes only while an element is being collected
  assert property (@(posedge CLK) disable iff (RST)
                   (a_enable || b_enable) |-> (state == mmul_pkg::vec_collect))
    else $error("vector_multiplier: operand strobe outside input phase");

endmodule

// File: logic/matrix_multiplier.sv
/*
  Modular matrix-product engine, top level.
  Latches the configuration, walks the rows through the row engine
  and registers each result onto the column, row and ready strobes.
*/

`timescale 1ns/100ps

module matrix_multiplier (
  input  logic               CLK,
  input  logic               RST,
  input  logic               start,
  input  mmul_pkg::mat_cfg_t cfg,
  input  logic               a_enable,
  input  logic               b_enable,
  input  mmul_pkg::data_t    data_a,
  input  mmul_pkg::data_t    data_b,
  output logic               out_i_enable,
  output logic               out_j_enable,
  output logic               ready,
  output mmul_pkg::data_t    data_out
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  mmul_pkg::mat_state_t state;

  // Configuration held for the whole matrix
  mmul_pkg::mat_cfg_t cfg_reg;

  // Current row
  mmul_pkg::index_t row_cnt;

  // Row engine interface
  logic            row_start;
  logic            elem_enable;
  mmul_pkg::data_t elem_data;
  logic            row_done;

  // Final row reached
  logic last_row;

  assign last_row = (row_cnt == cfg_reg.size_i - 1'b1);

  ////////////////////////////////////////////////////////////
  // Row loop
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= mmul_pkg::mat_idle;
      row_cnt <= '0;
      row_start <= 1'b0;
      out_i_enable <= 1'b0;
      out_j_enable <= 1'b0;
      ready <= 1'b0;
      data_out <= '0;
    end else begin
      // Strobes last one cycle
      row_start <= 1'b0;
      out_i_enable <= 1'b0;
      out_j_enable <= 1'b0;
      ready <= 1'b0;
      case (state)
        mmul_pkg::mat_idle: begin
          if (start) begin
            row_cnt <= '0;
            // First row opens right after the config is latched
            row_start <= 1'b1;
            state <= mmul_pkg::mat_row;
          end
        end
        mmul_pkg::mat_row: begin
          if (elem_enable) begin
            // One extra register stage onto the outputs
            out_j_enable <= 1'b1;
            out_i_enable <= row_done;
            data_out <= elem_data;
            if (row_done) begin
              if (last_row) begin
                ready <= 1'b1;
                state <= mmul_pkg::mat_finish;
              end else begin
                row_cnt <= row_cnt + 1'b1;
                row_start <= 1'b1;
              end
            end
          end
        end
        default: begin
          // Ready cycle then back to waiting for a new matrix
          state <= mmul_pkg::mat_idle;
        end
      endcase
    end
  end

  // Configuration latch
  always_ff @(posedge CLK) begin
    if (state == mmul_pkg::mat_idle && start) begin
      cfg_reg <= cfg;
    end
  end

  ////////////////////////////////////////////////////////////
  // Row engine
  ////////////////////////////////////////////////////////////

  vector_multiplier u_row (
    .CLK         (CLK),
    .RST         (RST),
    .row_start   (row_start),
    .modulo      (cfg_reg.modulo),
    .size_j      (cfg_reg.size_j),
    .a_enable    (a_enable),
    .b_enable    (b_enable),
    .data_a      (data_a),
    .data_b      (data_b),
    .elem_enable (elem_enable),
    .elem_data   (elem_data),
    .row_done    (row_done)
  );

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Zero sizes never finish a row and zero modulus breaks reduction
  assert property (@(posedge CLK) disable iff (RST)
                   start |-> (cfg.size_i != '0 && cfg.size_j != '0 && cfg.modulo != '0))
    else $error("matrix_multiplier: zero size or modulus at start");

endmodule

// File: bench/bench_clock.sv
/*
  Testbench clock and reset.
  4 ns clock, reset held high over the first 5 rising edges.
*/

`timescale 1ns/100ps

module bench_clock (
  output logic CLK,
  output logic RST
);

  // Free-running clock, 2 ns per phase
  initial begin
    CLK = 1'b0;
    forever begin
      #2 CLK = ~CLK;
    end
  end

  // Release lines up with the stimulus offset after the edge
  initial begin
    RST = 1'b1;
    repeat (5) @(posedge CLK);
    #1 RST = 1'b0;
  end

endmodule

// File: bench/matrix_bench.sv
/*
  Testbench for the modular matrix-product engine.
  Directed and LFSR-driven matrices, reference model and a result queue
  checked against every column strobe.
*/

`timescale 1ns/100ps

module matrix_bench;

  ////////////////////////////////////////////////////////////
  // Constants and types
  ////////////////////////////////////////////////////////////

  localparam int unsigned random_mats = 20;
  localparam int unsigned directed_mats = 4;
  // Worst case 16 elements per matrix at 30 cycles each
  localparam int unsigned cycle_limit = (random_mats + directed_mats) * 16 * 30 + 500;
  // Strobe to out_j_enable
  localparam int unsigned result_latency = 21;
  localparam int unsigned result_wait = 40;

  // Operand selection
  localparam logic [1:0] op_rand = 2'd0;
  localparam logic [1:0] op_max = 2'd1;
  localparam logic [1:0] op_zero = 2'd2;

  // One expected result with its strobes and due cycle
  typedef struct packed {
    mmul_pkg::data_t value;
    logic            row_end;
    logic            last;
    logic [31:0]     due;
  } result_t;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  logic               CLK;
  logic               RST;
  logic               start;
  mmul_pkg::mat_cfg_t cfg;
  logic               a_enable;
  logic               b_enable;
  mmul_pkg::data_t    data_a;
  mmul_pkg::data_t    data_b;
  logic               out_i_enable;
  logic               out_j_enable;
  logic               ready;
  mmul_pkg::data_t    data_out;

  logic [31:0] cycle_cnt = '0;
  logic [31:0] lfsr_state = 32'h56d7;
  result_t     exp_q[$];
  result_t     popped;

  // Counts from the comparison process
  int unsigned seen_cnt = 0;
  int unsigned row_end_cnt = 0;
  int unsigned ready_cnt = 0;
  int unsigned value_errs = 0;
  int unsigned strobe_errs = 0;

  // Counts from the stimulus process
  int unsigned seq_errs = 0;
  int unsigned sent_cnt = 0;
  int unsigned lost_cnt = 0;
  int unsigned mats_done = 0;
  int unsigned rows_total = 0;
  int unsigned k;

  bench_clock clock_gen (
    .CLK (CLK),
    .RST (RST)
  );

  matrix_multiplier dut (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .cfg          (cfg),
    .a_enable     (a_enable),
    .b_enable     (b_enable),
    .data_a       (data_a),
    .data_b       (data_b),
    .out_i_enable (out_i_enable),
    .out_j_enable (out_j_enable),
    .ready        (ready),
    .data_out     (data_out)
  );

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 32'd1;
  end

  ////////////////////////////////////////////////////////////
  // Random source and reference
  ////////////////////////////////////////////////////////////

  // Galois LFSR with x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // Random operand kept below the modulus
  function automatic mmul_pkg::data_t below(input mmul_pkg::data_t m);
    return mmul_pkg::data_t'(take_bits(16) % {16'h0, m});
  endfunction

  // Full-width product then the remainder
  function automatic mmul_pkg::data_t mod_product(input mmul_pkg::data_t m,
                                                  input mmul_pkg::data_t a,
                                                  input mmul_pkg::data_t b);
    logic [31:0] full;
    full = {16'h0, a} * {16'h0, b};
    return mmul_pkg::data_t'(full % {16'h0, m});
  endfunction

  function automatic mmul_pkg::mat_cfg_t make_cfg(input mmul_pkg::data_t m,
                                                  input mmul_pkg::index_t rows,
                                                  input mmul_pkg::index_t cols);
    mmul_pkg::mat_cfg_t c;
    c.modulo = m;
    c.size_i = rows;
    c.size_j = cols;
    return c;
  endfunction

  // Sizes 1 to 4 and a small or full-range modulus
  function automatic mmul_pkg::mat_cfg_t random_cfg();
    mmul_pkg::mat_cfg_t c;
    c.size_i = mmul_pkg::index_t'(take_bits(2) + 32'd1);
    c.size_j = mmul_pkg::index_t'(take_bits(2) + 32'd1);
    if (take_bits(1) == 32'd1) begin
      c.modulo = mmul_pkg::data_t'(take_bits(5));
    end else begin
      c.modulo = mmul_pkg::data_t'(take_bits(16));
    end
    // Zero modulus is illegal so 1 stands in
    if (c.modulo == '0) begin
      c.modulo = 16'd1;
    end
    return c;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge CLK);
    #1;
  endtask

  task automatic check_quiet();
    if (ready !== 1'b0) begin
      $display("** Error at %0t: ready expected 0, got %b", $time, ready);
      seq_errs++;
    end
    if (out_i_enable !== 1'b0) begin
      $display("** Error at %0t: out_i_enable expected 0, got %b", $time, out_i_enable);
      seq_errs++;
    end
    if (out_j_enable !== 1'b0) begin
      $display("** Error at %0t: out_j_enable expected 0, got %b", $time, out_j_enable);
      seq_errs++;
    end
    if (data_out !== 16'h0000) begin
      $display("** Error at %0t: data_out expected 0000, got %h", $time, data_out);
      seq_errs++;
    end
  endtask

  // Order 0 is same cycle, 1 is A then B and 2 is B then A
  task automatic send_element(input mmul_pkg::data_t a, input mmul_pkg::data_t b,
                              input logic [1:0] order, input logic [1:0] gap,
                              output logic [31:0] due);
    case (order)
      2'd1: begin
        a_enable = 1'b1;
        data_a = a;
        tick();
        a_enable = 1'b0;
        repeat (gap) tick();
        due = cycle_cnt + result_latency;
        b_enable = 1'b1;
        data_b = b;
        tick();
        b_enable = 1'b0;
      end
      2'd2: begin
        b_enable = 1'b1;
        data_b = b;
        tick();
        b_enable = 1'b0;
        repeat (gap) tick();
        due = cycle_cnt + result_latency;
        a_enable = 1'b1;
        data_a = a;
        tick();
        a_enable = 1'b0;
      end
      default: begin
        due = cycle_cnt + result_latency;
        a_enable = 1'b1;
        b_enable = 1'b1;
        data_a = a;
        data_b = b;
        tick();
        a_enable = 1'b0;
        b_enable = 1'b0;
      end
    endcase
  endtask

  // Next element only after the previous result
  task automatic wait_result(input int unsigned target);
    int unsigned waited;
    waited = 0;
    while (seen_cnt < target && waited < result_wait) begin
      tick();
      waited++;
    end
    if (seen_cnt < target) begin
      $display("No out_j_enable for result %0d within %0d cycles at %0t",
               target, result_wait, $time);
      seq_errs++;
      lost_cnt++;
      // Lost entry dropped to keep the queue aligned
      if (exp_q.size() != 0) begin
        exp_q.delete(0);
      end
    end
  endtask

  task automatic run_matrix(input mmul_pkg::mat_cfg_t c, input logic [1:0] kind);
    mmul_pkg::data_t a;
    mmul_pkg::data_t b;
    logic [1:0]      order;
    logic [1:0]      gap;
    logic [31:0]     due;
    result_t         e;
    int              i;
    int              j;
    cfg = c;
    start = 1'b1;
    tick();
    start = 1'b0;
    tick();
    for (i = 0; i < int'(c.size_i); i++) begin
      for (j = 0; j < int'(c.size_j); j++) begin
        case (kind)
          op_max: begin
            a = c.modulo - 16'd1;
            b = c.modulo - 16'd1;
          end
          op_zero: begin
            // Zero on alternating sides
            a = j[0] ? 16'd0 : below(c.modulo);
            b = j[0] ? below(c.modulo) : 16'd0;
          end
          default: begin
            a = below(c.modulo);
            b = below(c.modulo);
          end
        endcase
        order = 2'(take_bits(2) % 32'd3);
        gap = 2'(take_bits(2));
        // Occasional idle cycle before the element
        if (take_bits(1) == 32'd1) begin
          tick();
        end
        send_element(a, b, order, gap, due);
        e.value = mod_product(c.modulo, a, b);
        e.row_end = (j == int'(c.size_j) - 1);
        e.last = e.row_end && (i == int'(c.size_i) - 1);
        e.due = due;
        exp_q.push_back(e);
        sent_cnt++;
        wait_result(sent_cnt - lost_cnt);
      end
    end
    mats_done++;
    rows_total += int'(c.size_i);
  endtask

  task automatic print_summary();
    $display("Errors: value %0d, strobe %0d, sequence %0d, results seen %0d of %0d",
             value_errs, strobe_errs, seq_errs, seen_cnt, sent_cnt);
  endtask

  ////////////////////////////////////////////////////////////
  // Result comparison
  ////////////////////////////////////////////////////////////

  // Pre-edge output values with one queue entry per column strobe
  always @(posedge CLK) begin
    if (!RST) begin
      if (out_j_enable) begin
        seen_cnt++;
        if (out_i_enable) row_end_cnt++;
        if (ready) ready_cnt++;
        if (exp_q.size() == 0) begin
          $display("Unexpected out_j_enable at %0t with no result pending", $time);
          strobe_errs++;
        end else begin
          popped = exp_q.pop_front();
          if (data_out !== popped.value) begin
            $display("** Error at %0t: data_out expected %h, got %h",
                     $time, popped.value, data_out);
            value_errs++;
          end
          if (out_i_enable !== popped.row_end) begin
            $display("** Error at %0t: out_i_enable expected %b, got %b",
                     $time, popped.row_end, out_i_enable);
            value_errs++;
          end
          if (ready !== popped.last) begin
            $display("** Error at %0t: ready expected %b, got %b", $time, popped.last, ready);
            value_errs++;
          end
          if (cycle_cnt != popped.due) begin
            $display("** Error at %0t: out_j_enable cycle expected %0d, got %0d",
                     $time, popped.due, cycle_cnt);
            value_errs++;
          end
        end
      end else if (out_i_enable || ready) begin
        $display("Row end or ready strobe at %0t without out_j_enable", $time);
        strobe_errs++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    while (cycle_cnt < cycle_limit) begin
      @(posedge CLK);
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    print_summary();
    $display("Verification failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    start = 1'b0;
    cfg = '0;
    a_enable = 1'b0;
    b_enable = 1'b0;
    data_a = '0;
    data_b = '0;

    // Outputs quiet during and right after reset
    do begin
      @(negedge CLK);
      if (RST) check_quiet();
    end while (RST);
    repeat (3) begin
      @(negedge CLK);
      check_quiet();
    end
    tick();

    // Directed corners
    run_matrix(make_cfg(16'd251, 8'd1, 8'd1), op_rand);
    run_matrix(make_cfg(16'd1, 8'd3, 8'd2), op_rand);
    run_matrix(make_cfg(16'hffff, 8'd2, 8'd2), op_max);
    run_matrix(make_cfg(16'd1009, 8'd2, 8'd3), op_zero);

    for (k = 0; k < random_mats; k++) begin
      run_matrix(random_cfg(), op_rand);
    end

    // Room for any stray strobe
    repeat (5) tick();

    if (exp_q.size() != 0) begin
      $display("%0d expected results never appeared", exp_q.size());
      seq_errs++;
    end
    if (ready_cnt != mats_done) begin
      $display("ready pulsed %0d times for %0d matrices", ready_cnt, mats_done);
      seq_errs++;
    end
    if (row_end_cnt != rows_total) begin
      $display("out_i_enable pulsed %0d times for %0d rows", row_end_cnt, rows_total);
      seq_errs++;
    end

    print_summary();
    if (value_errs + strobe_errs + seq_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: list.f
logic/mmul_pkg.sv
logic/modular_multiplier.sv
logic/vector_multiplier.sv
logic/matrix_multiplier.sv
bench/bench_clock.sv
bench/matrix_bench.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the matrix engine testbench
set -e

cd "$(dirname "$0")"

# Fresh build tree
rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module matrix_bench \
  -f list.f \
  -o matrix_sim

# Simulator output kept for the result search
./obj_dir/matrix_sim 2>&1 | tee sim.log

if grep -qx "Verification passed" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
